//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := calc_tb
FILELIST := project.f

BUILD_DIR := obj_dir
BIN       := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(BUILD_DIR)

//--- dv/calc_tb.sv
`timescale 1ns/1ns
`default_nettype none

module calc_tb;

	localparam int period    = 4;	// ns
	localparam int num_trans = 16 + 16 + 48 + 80 + 160;	// all sections together
	localparam int max_lat   = 7;	// cycles from operand-2 edge to response

	logic               c_clk;
	logic               rst;
	calc_op_pkg::cmd_t  cmd_in [calc_port_pkg::num_ports];
	calc_op_pkg::data_t data_in [calc_port_pkg::num_ports];
	calc_op_pkg::resp_t resp_out [calc_port_pkg::num_ports];
	calc_op_pkg::data_t data_out [calc_port_pkg::num_ports];

	int                 seed = 32'h692a_1375;
	int                 cycle_count = 0;
	logic [33:0]        exp_q [calc_port_pkg::num_ports][$];	// {resp, data}
	int                 op2_edge_q [calc_port_pkg::num_ports][$];
	calc_op_pkg::cmd_t  next_cmd [calc_port_pkg::num_ports];
	calc_op_pkg::data_t next_a [calc_port_pkg::num_ports];
	calc_op_pkg::data_t next_b [calc_port_pkg::num_ports];
	calc_op_pkg::cmd_t  valid_ops [4] = '{calc_op_pkg::cmd_add, calc_op_pkg::cmd_sub,
		calc_op_pkg::cmd_shl, calc_op_pkg::cmd_shr};

	calc_top i_dut (
		.c_clk, .rst,
		.req1_cmd  (cmd_in[0]), .req2_cmd  (cmd_in[1]),
		.req3_cmd  (cmd_in[2]), .req4_cmd  (cmd_in[3]),
		.req1_data (data_in[0]), .req2_data (data_in[1]),
		.req3_data (data_in[2]), .req4_data (data_in[3]),
		.out_resp1 (resp_out[0]), .out_resp2 (resp_out[1]),
		.out_resp3 (resp_out[2]), .out_resp4 (resp_out[3]),
		.out_data1 (data_out[0]), .out_data2 (data_out[1]),
		.out_data3 (data_out[2]), .out_data4 (data_out[3])
	);

	initial c_clk = 1'b0;
	always #(period / 2) c_clk = ~c_clk;

	always @(posedge c_clk) cycle_count <= cycle_count + 1;

	task automatic stop_run(input string reason);
		$display("%s", reason);
		$display("Test failed");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected)
			stop_run($sformatf("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got,
				expected));
	endtask

	// reference behavior of one command, response in the top two bits
	function automatic logic [33:0] expected_result(input logic [3:0] cmd,
		input logic [31:0] a, input logic [31:0] b);
		logic [1:0]  r;
		logic [31:0] d;
		r = calc_op_pkg::resp_ok;
		d = '0;
		case (cmd)
			calc_op_pkg::cmd_add: begin
				if (b > 32'hffff_ffff - a) r = calc_op_pkg::resp_range_err;	// sum too wide
				else d = a + b;
			end
			calc_op_pkg::cmd_sub: begin
				if (b > a) r = calc_op_pkg::resp_range_err;
				else d = a - b;
			end
			calc_op_pkg::cmd_shl: d = a << b[4:0];
			calc_op_pkg::cmd_shr: d = a >> b[4:0];
			calc_op_pkg::cmd_nop: r = calc_op_pkg::resp_none;
			default: r = calc_op_pkg::resp_bad_cmd;
		endcase
		return {r, d};
	endfunction

	function automatic int outstanding();
		int n;
		n = 0;
		for (int p = 0; p < calc_port_pkg::num_ports; p++) n += exp_q[p].size();
		return n;
	endfunction

	// each response must match the oldest expectation of its port
	always @(negedge c_clk) begin
		logic [33:0] exp;
		int          issued;
		for (int p = 0; p < calc_port_pkg::num_ports; p++) begin
			if (!rst && resp_out[p] != calc_op_pkg::resp_none) begin
				if (exp_q[p].size() == 0)
					stop_run($sformatf("port %0d gave a response with no command outstanding",
						p + 1));
				exp    = exp_q[p].pop_front();
				issued = op2_edge_q[p].pop_front();
				check_value($sformatf("port %0d response", p + 1), 32'(resp_out[p]),
					32'(exp[33:32]));
				check_value($sformatf("port %0d data", p + 1), data_out[p], exp[31:0]);
				if (cycle_count - issued > max_lat)
					stop_run($sformatf("port %0d responded %0d cycles after operand 2",
						p + 1, cycle_count - issued));
			end
		end
	end

	// drives the staged commands of the masked ports in the same cycle
	task automatic launch(input logic [3:0] mask);
		for (int p = 0; p < calc_port_pkg::num_ports; p++) begin
			if (mask[p]) begin
				cmd_in[p]  = next_cmd[p];
				data_in[p] = next_a[p];
			end
		end
		@(posedge c_clk);
		#1;
		for (int p = 0; p < calc_port_pkg::num_ports; p++) begin
			if (mask[p]) begin
				cmd_in[p]  = calc_op_pkg::cmd_nop;
				data_in[p] = next_b[p];	// operand 2 on the following edge
				if (next_cmd[p] != calc_op_pkg::cmd_nop) begin
					exp_q[p].push_back(expected_result(next_cmd[p], next_a[p], next_b[p]));
					op2_edge_q[p].push_back(cycle_count + 1);
				end
			end
		end
	endtask

	task automatic wait_drained();
		do @(posedge c_clk); while (outstanding() != 0);
		#1;
	endtask

	task automatic run_one(input int p, input logic [3:0] cmd, input logic [31:0] a,
		input logic [31:0] b);
		next_cmd[p] = cmd;
		next_a[p]   = a;
		next_b[p]   = b;
		launch(4'b0001 << p);
		wait_drained();
	endtask

	initial begin
		#(num_trans * 12 * period);
		stop_run("timeout: responses stopped arriving before the tests finished");
	end

	initial begin
		int p;
		rst = 1'b1;
		for (int i = 0; i < calc_port_pkg::num_ports; i++) begin
			cmd_in[i]  = calc_op_pkg::cmd_nop;
			data_in[i] = '0;
		end
		repeat (5) @(posedge c_clk);
		#1 rst = 1'b0;

		for (int i = 0; i < calc_port_pkg::num_ports; i++) begin
			run_one(i, calc_op_pkg::cmd_nop, 32'd5, 32'd7);
			repeat (10) @(posedge c_clk);	// monitor flags any response here
			#1;
			run_one(i, calc_op_pkg::cmd_add, 32'd64, 32'd27);
			run_one(i, calc_op_pkg::cmd_add, 32'hffff_ffff, 32'd1);
			run_one(i, calc_op_pkg::cmd_sub, 32'd22, 32'd23);
		end

		for (int i = 0; i < calc_port_pkg::num_ports; i++) begin
			run_one(i, calc_op_pkg::cmd_add, 32'h1234_5678, 32'h0101_0101);
			run_one(i, calc_op_pkg::cmd_sub, 32'h8000_0000, 32'd1);
			run_one(i, calc_op_pkg::cmd_shl, 32'h0000_00f1, 32'h24);	// amount 4
			run_one(i, calc_op_pkg::cmd_shr, 32'hf000_0000, 32'h3f);	// amount 31
		end

		repeat (48) begin	// all sixteen codes, unused ones too
			p = $unsigned($random(seed)) % calc_port_pkg::num_ports;
			run_one(p, 4'($random(seed)), $random(seed), $random(seed));
		end

		repeat (80) begin
			p = $unsigned($random(seed)) % calc_port_pkg::num_ports;
			run_one(p, valid_ops[$unsigned($random(seed)) % 4], $random(seed), $random(seed));
		end

		repeat (40) begin	// all ports contend for the units
			for (int i = 0; i < calc_port_pkg::num_ports; i++) begin
				next_cmd[i] = valid_ops[$unsigned($random(seed)) % 4];
				next_a[i]   = $random(seed);
				next_b[i]   = $random(seed);
			end
			launch(4'b1111);
			wait_drained();
		end

		repeat (10) @(posedge c_clk);
		if (outstanding() != 0) begin
			stop_run("tests ended with responses still outstanding");
		end else begin
			$display("Test passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- logic/calc_alu_addsub.sv
`timescale 1ns/1ns
`default_nettype none

module calc_alu_addsub (
	input  wire logic                     c_clk,
	input  wire logic                     rst,
	input  wire logic                     in_valid,
	input  wire calc_port_pkg::port_idx_t in_port,
	input  wire logic                     in_sub,
	input  wire calc_op_pkg::data_t       op1,
	input  wire calc_op_pkg::data_t       op2,
	calc_done_if.source                   done
);

	logic                        s1_valid;
	calc_port_pkg::port_idx_t    s1_port;
	logic [calc_op_pkg::data_w:0] s1_sum;	// top bit is carry on add, borrow on sub

	always_ff @(posedge c_clk) begin
		if (rst) begin
			s1_valid   <= 1'b0;
			done.valid <= 1'b0;
		end else begin
			s1_valid   <= in_valid;
			done.valid <= s1_valid;
		end
	end

	always_ff @(posedge c_clk) begin
		s1_port <= in_port;
		if (in_sub) begin
			s1_sum <= {1'b0, op1} - {1'b0, op2};	// borrow set when op2 > op1
		end else begin
			s1_sum <= {1'b0, op1} + {1'b0, op2};
		end

		done.port <= s1_port;
		if (s1_sum[calc_op_pkg::data_w]) begin
			done.resp <= calc_op_pkg::resp_range_err;
			done.data <= '0;
		end else begin
			done.resp <= calc_op_pkg::resp_ok;
			done.data <= s1_sum[calc_op_pkg::data_w-1:0];
		end
	end

endmodule

`default_nettype wire

//--- logic/calc_alu_shift.sv
`timescale 1ns/1ns
`default_nettype none

module calc_alu_shift (
	input  wire logic                     c_clk,
	input  wire logic                     rst,
	input  wire logic                     in_valid,
	input  wire calc_port_pkg::port_idx_t in_port,
	input  wire logic                     in_left,
	input  wire calc_op_pkg::data_t       op1,
	input  wire calc_op_pkg::data_t       op2,
	calc_done_if.source                   done
);

	logic                           s1_valid;
	calc_port_pkg::port_idx_t       s1_port;
	logic                           s1_left;
	calc_op_pkg::data_t             s1_val;
	logic [calc_op_pkg::shamt_w-1:0] s1_amt;

	always_ff @(posedge c_clk) begin
		if (rst) begin
			s1_valid   <= 1'b0;
			done.valid <= 1'b0;
		end else begin
			s1_valid   <= in_valid;
			done.valid <= s1_valid;
		end
	end

	always_ff @(posedge c_clk) begin
		s1_port <= in_port;
		s1_left <= in_left;
		s1_val  <= op1;
		s1_amt  <= op2[calc_op_pkg::shamt_w-1:0];	// upper bits ignored

		done.port <= s1_port;
		done.resp <= calc_op_pkg::resp_ok;	// a shift cannot fail
		if (s1_left) begin
			done.data <= s1_val << s1_amt;
		end else begin
			done.data <= s1_val >> s1_amt;	// logical, zero fill
		end
	end

endmodule

`default_nettype wire

//--- logic/calc_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module calc_arbiter (
	input  wire logic                                c_clk,
	input  wire logic                                rst,
	input  wire logic [calc_port_pkg::num_ports-1:0] request,
	output logic [calc_port_pkg::num_ports-1:0]      grant
);

	calc_port_pkg::port_idx_t prio;	// port with highest priority this cycle
	calc_port_pkg::port_idx_t winner;

	// walk from the far end so the nearest requester after prio wins
	always_comb begin
		grant  = '0;
		winner = prio;
		for (int k = calc_port_pkg::num_ports - 1; k >= 0; k--) begin
			calc_port_pkg::port_idx_t idx;
			idx = calc_port_pkg::port_idx_t'((int'(prio) + k) % calc_port_pkg::num_ports);
			if (request[idx]) winner = idx;
		end
		if (|request) grant[winner] = 1'b1;
	end

	always_ff @(posedge c_clk) begin
		if (rst) begin
			prio <= '0;
		end else if (|request) begin
			prio <= calc_port_pkg::port_idx_t'((int'(winner) + 1) % calc_port_pkg::num_ports);
		end
	end

	a_grant_legal: assert property (@(posedge c_clk) disable iff (rst)
		$onehot0(grant) && ((grant & ~request) == '0));

endmodule

`default_nettype wire

//--- logic/calc_execute.sv
`timescale 1ns/1ns
`default_nettype none

module calc_execute (
	input  wire logic c_clk,
	input  wire logic rst,
	calc_req_if.execute req [calc_port_pkg::num_ports],
	calc_done_if.source addsub_done,
	calc_done_if.source shift_done
);

	logic [calc_port_pkg::num_ports-1:0] as_req, sh_req;
	logic [calc_port_pkg::num_ports-1:0] as_grant, sh_grant;
	calc_op_pkg::op_kind_t               kind [calc_port_pkg::num_ports];
	calc_op_pkg::data_t                  op1 [calc_port_pkg::num_ports];
	calc_op_pkg::data_t                  op2 [calc_port_pkg::num_ports];
	calc_port_pkg::port_idx_t            as_port, sh_port;

	for (genvar i = 0; i < calc_port_pkg::num_ports; i++) begin : g_port
		assign kind[i]   = req[i].kind;
		assign op1[i]    = req[i].op1;
		assign op2[i]    = req[i].op2;
		assign as_req[i] = req[i].valid &&
			(req[i].kind == calc_op_pkg::op_add || req[i].kind == calc_op_pkg::op_sub);
		assign sh_req[i] = req[i].valid &&
			(req[i].kind == calc_op_pkg::op_shl || req[i].kind == calc_op_pkg::op_shr);
		assign req[i].grant = as_grant[i] | sh_grant[i];	// a port asks one unit only
	end

	calc_arbiter u_arb_addsub (.c_clk, .rst, .request(as_req), .grant(as_grant));
	calc_arbiter u_arb_shift (.c_clk, .rst, .request(sh_req), .grant(sh_grant));

	// one-hot grant to port index
	always_comb begin
		as_port = '0;
		sh_port = '0;
		for (int j = 0; j < calc_port_pkg::num_ports; j++) begin
			if (as_grant[j]) as_port = calc_port_pkg::port_idx_t'(j);
			if (sh_grant[j]) sh_port = calc_port_pkg::port_idx_t'(j);
		end
	end

	calc_alu_addsub u_addsub (
		.c_clk, .rst,
		.in_valid (|as_grant),
		.in_port  (as_port),
		.in_sub   (kind[as_port] == calc_op_pkg::op_sub),
		.op1      (op1[as_port]),
		.op2      (op2[as_port]),
		.done     (addsub_done)
	);

	calc_alu_shift u_shift (
		.c_clk, .rst,
		.in_valid (|sh_grant),
		.in_port  (sh_port),
		.in_left  (kind[sh_port] == calc_op_pkg::op_shl),
		.op1      (op1[sh_port]),
		.op2      (op2[sh_port]),
		.done     (shift_done)
	);

endmodule

`default_nettype wire

//--- logic/calc_if.sv
`timescale 1ns/1ns
`default_nettype none

// one per port, decode to execute
interface calc_req_if;

	logic                  valid;	// held until granted
	calc_op_pkg::op_kind_t kind;
	calc_op_pkg::data_t    op1;
	calc_op_pkg::data_t    op2;
	logic                  grant;	// same-cycle accept

	modport request (
		output valid, kind, op1, op2,
		input  grant
	);

	modport execute (
		input  valid, kind, op1, op2,
		output grant
	);

endinterface

// one per unit, single-cycle completion pulse
interface calc_done_if;

	logic                     valid;
	calc_port_pkg::port_idx_t port;	// port that issued the request
	calc_op_pkg::resp_t       resp;
	calc_op_pkg::data_t       data;

	modport source (output valid, port, resp, data);

	modport sink (input valid, port, resp, data);

endinterface

`default_nettype wire

//--- logic/calc_op_pkg.sv
`default_nettype none

package calc_op_pkg;

	localparam int data_w  = 32;	// operand and result width
	localparam int shamt_w = 5;	// only these low bits of operand 2 shift

	typedef logic [data_w-1:0] data_t;

	// raw port code, unused values must still pass through to the decoder
	typedef logic [3:0] cmd_t;

	localparam cmd_t cmd_nop = 4'd0;
	localparam cmd_t cmd_add = 4'd1;
	localparam cmd_t cmd_sub = 4'd2;	// operand 1 minus operand 2
	localparam cmd_t cmd_shl = 4'd5;
	localparam cmd_t cmd_shr = 4'd6;

	typedef enum logic [1:0] {
		resp_none      = 2'd0,
		resp_ok        = 2'd1,
		resp_range_err = 2'd2,	// add overflow or sub underflow
		resp_bad_cmd   = 2'd3
	} resp_t;

	typedef enum logic [1:0] {
		op_add = 2'd0,
		op_sub = 2'd1,
		op_shl = 2'd2,
		op_shr = 2'd3
	} op_kind_t;

endpackage

`default_nettype wire

//--- logic/calc_port_decode.sv
`timescale 1ns/1ns
`default_nettype none

module calc_port_decode (
	input  wire logic               c_clk,
	input  wire logic               rst,
	input  wire calc_op_pkg::cmd_t  cmd,
	input  wire calc_op_pkg::data_t data,
	calc_req_if.request             req,
	output logic                    bad_cmd
);

	typedef enum logic [1:0] {
		st_idle,	// waiting for a command
		st_op2,	// command and operand 1 held, operand 2 due
		st_req	// request raised until granted
	} state_t;

	state_t state;
	logic   bad_q;	// captured command has no operation

	always_ff @(posedge c_clk) begin
		if (rst) begin
			state   <= st_idle;
			bad_cmd <= 1'b0;
		end else begin
			bad_cmd <= 1'b0;	// strobe lasts one cycle
			case (state)
				st_idle: begin
					if (cmd != calc_op_pkg::cmd_nop) state <= st_op2;
				end
				st_op2: begin
					if (bad_q) begin
						bad_cmd <= 1'b1;
						state   <= st_idle;	// nothing to execute
					end else begin
						state <= st_req;
					end
				end
				st_req: begin
					if (req.grant) state <= st_idle;
				end
				default: state <= st_idle;
			endcase
		end
	end

	// capture registers, loaded in whichever state owns them
	always_ff @(posedge c_clk) begin
		if (state == st_idle) begin
			req.op1 <= data;
			bad_q   <= 1'b0;
			case (cmd)
				calc_op_pkg::cmd_add: req.kind <= calc_op_pkg::op_add;
				calc_op_pkg::cmd_sub: req.kind <= calc_op_pkg::op_sub;
				calc_op_pkg::cmd_shl: req.kind <= calc_op_pkg::op_shl;
				calc_op_pkg::cmd_shr: req.kind <= calc_op_pkg::op_shr;
				default: begin
					req.kind <= calc_op_pkg::op_add;
					bad_q    <= 1'b1;
				end
			endcase
		end
		if (state == st_op2) req.op2 <= data;
	end

	assign req.valid = (state == st_req);

	// the port may only start a command from idle
	a_one_outstanding: assert property (@(posedge c_clk) disable iff (rst)
		(cmd != calc_op_pkg::cmd_nop) |-> (state == st_idle));

endmodule

`default_nettype wire

//--- logic/calc_port_pkg.sv
`default_nettype none

package calc_port_pkg;

	localparam int num_ports  = 4;
	localparam int pipe_depth = 2;	// stages in each execution unit

	typedef logic [$clog2(num_ports)-1:0] port_idx_t;

endpackage

`default_nettype wire

//--- logic/calc_result.sv
`timescale 1ns/1ns
`default_nettype none

module calc_result (
	input  wire logic                                c_clk,
	input  wire logic                                rst,
	calc_done_if.sink                                addsub_done,
	calc_done_if.sink                                shift_done,
	input  wire logic [calc_port_pkg::num_ports-1:0] bad_cmd,
	output calc_op_pkg::resp_t                       resp [calc_port_pkg::num_ports],
	output calc_op_pkg::data_t                       data [calc_port_pkg::num_ports]
);

	for (genvar p = 0; p < calc_port_pkg::num_ports; p++) begin : g_port
		logic as_hit, sh_hit;

		assign as_hit = addsub_done.valid && (addsub_done.port == calc_port_pkg::port_idx_t'(p));
		assign sh_hit = shift_done.valid && (shift_done.port == calc_port_pkg::port_idx_t'(p));

		// response shows for one cycle, then back to none
		always_ff @(posedge c_clk) begin
			if (rst) begin
				resp[p] <= calc_op_pkg::resp_none;
			end else if (as_hit) begin
				resp[p] <= addsub_done.resp;
			end else if (sh_hit) begin
				resp[p] <= shift_done.resp;
			end else if (bad_cmd[p]) begin
				resp[p] <= calc_op_pkg::resp_bad_cmd;
			end else begin
				resp[p] <= calc_op_pkg::resp_none;
			end
		end

		always_ff @(posedge c_clk) begin
			if (as_hit) begin
				data[p] <= addsub_done.data;
			end else if (sh_hit) begin
				data[p] <= shift_done.data;
			end else if (bad_cmd[p]) begin
				data[p] <= '0;	// invalid command carries zero data
			end
		end

		// one outstanding command per port means at most one source per cycle
		a_single_source: assert property (@(posedge c_clk) disable iff (rst)
			$onehot0({as_hit, sh_hit, bad_cmd[p]}));
	end

endmodule

`default_nettype wire

//--- logic/calc_top.sv
`timescale 1ns/1ns
`default_nettype none

module calc_top (
	input  wire logic               c_clk,
	input  wire logic               rst,
	input  wire calc_op_pkg::cmd_t  req1_cmd,
	input  wire calc_op_pkg::cmd_t  req2_cmd,
	input  wire calc_op_pkg::cmd_t  req3_cmd,
	input  wire calc_op_pkg::cmd_t  req4_cmd,
	input  wire calc_op_pkg::data_t req1_data,
	input  wire calc_op_pkg::data_t req2_data,
	input  wire calc_op_pkg::data_t req3_data,
	input  wire calc_op_pkg::data_t req4_data,
	output calc_op_pkg::resp_t      out_resp1,
	output calc_op_pkg::resp_t      out_resp2,
	output calc_op_pkg::resp_t      out_resp3,
	output calc_op_pkg::resp_t      out_resp4,
	output calc_op_pkg::data_t      out_data1,
	output calc_op_pkg::data_t      out_data2,
	output calc_op_pkg::data_t      out_data3,
	output calc_op_pkg::data_t      out_data4
);

	calc_op_pkg::cmd_t                   cmd [calc_port_pkg::num_ports];
	calc_op_pkg::data_t                  din [calc_port_pkg::num_ports];
	calc_op_pkg::resp_t                  resp [calc_port_pkg::num_ports];
	calc_op_pkg::data_t                  dout [calc_port_pkg::num_ports];
	logic [calc_port_pkg::num_ports-1:0] bad_cmd;

	calc_req_if  req_bus [calc_port_pkg::num_ports] ();
	calc_done_if addsub_done ();
	calc_done_if shift_done ();

	assign cmd = '{req1_cmd, req2_cmd, req3_cmd, req4_cmd};
	assign din = '{req1_data, req2_data, req3_data, req4_data};

	for (genvar i = 0; i < calc_port_pkg::num_ports; i++) begin : g_port
		calc_port_decode u_decode (
			.c_clk, .rst,
			.cmd     (cmd[i]),
			.data    (din[i]),
			.req     (req_bus[i]),
			.bad_cmd (bad_cmd[i])
		);
	end

	calc_execute u_execute (.c_clk, .rst, .req(req_bus), .addsub_done, .shift_done);

	calc_result u_result (.c_clk, .rst, .addsub_done, .shift_done, .bad_cmd,
		.resp(resp), .data(dout));

	assign out_resp1 = resp[0];
	assign out_resp2 = resp[1];
	assign out_resp3 = resp[2];
	assign out_resp4 = resp[3];
	assign out_data1 = dout[0];
	assign out_data2 = dout[1];
	assign out_data3 = dout[2];
	assign out_data4 = dout[3];

endmodule

`default_nettype wire

//--- project.f
logic/calc_op_pkg.sv
logic/calc_port_pkg.sv
logic/calc_if.sv
logic/calc_port_decode.sv
logic/calc_arbiter.sv
logic/calc_alu_addsub.sv
logic/calc_alu_shift.sv
logic/calc_execute.sv
logic/calc_result.sv
logic/calc_top.sv
dv/calc_tb.sv
